// ==== lease_cases.txt ====
// op(0 cfg,1 table,2 hit,3 miss,4 miss+stall,5 fill,f end)_addr/line_ref_stall_then
// data for writes, or exp line_swap_default_expired_multi_random_00 for misses
4_3_0100_05_3_0_1_0_0_0_00 // zero default lease, held 5 cycles
0_0_0000_00_00000002       // default lease 2
1_0_0000_00_00A00006       // entry 0: ref 00a0 lease 6
1_1_0000_00_00B00040       // entry 1: ref 00b0 lease 0x40
0_1_0000_00_00000001       // lease1 = 1
0_3_0000_00_000000B0       // dual ref 00b0
0_2_0000_00_00000000       // threshold 0
3_1_00A0_00_1_1_0_0_0_0_00 // cold start set 1, way 0
5_0_00A0_00_00000000
3_1_00A0_00_5_1_0_0_0_0_00 // way 1
5_0_00A0_00_00000000
3_1_00A0_00_9_1_0_0_0_0_00 // way 2
5_0_00A0_00_00000000
3_1_00A0_00_D_1_0_0_0_0_00 // way 3, set now full
5_0_00A0_00_00000000
2_0_00A0_00_00000000       // decay by hits on set 0
2_0_00A0_00_00000000
3_1_00A0_00_1_1_0_1_0_0_00 // only way 0 expired
5_0_00A0_00_00000000
2_0_00A0_00_00000000
3_5_00A0_00_5_1_0_1_1_0_00 // ways 1 and 2 expired
5_0_00A0_00_00000000
2_9_00B0_00_00000000       // dual ref gets lease1 on line 9
3_1_00A0_00_9_1_0_1_1_0_00 // line 9 already expired
5_0_00A0_00_00000000
2_1_00A0_00_00000000
2_D_00A0_00_00000000
3_1_0300_00_5_1_1_0_0_1_00 // nothing expired, random way
5_0_00A0_00_00000000
F_0_0000_00_00000000

// ==== sources.f ====
cache_geom_pkg.sv
lease_pkg.sv
lease_lookup_table.sv
lease_selector.sv
lease_register_file.sv
victim_selector.sv
lease_policy_fsm.sv
lease_cache_policy.sv
tb_lease_cache_policy.sv

// ==== Bender.yml ====
package:
  name: lease_cache_policy

sources:
  - cache_geom_pkg.sv
  - lease_pkg.sv
  - lease_lookup_table.sv
  - lease_selector.sv
  - lease_register_file.sv
  - victim_selector.sv
  - lease_policy_fsm.sv
  - lease_cache_policy.sv
  - target: simulation
    files:
      - tb_lease_cache_policy.sv

// ==== tb_lease_cache_policy.sv ====
/* self-checking testbench for the lease replacement policy
   replays lease_cases.txt: host writes, hits, fills and misses with expected responses */
module tb_lease_cache_policy;

	logic        clock_i, resetn_i, llt_wren_i, cfg_wren_i;
	logic [3:0]  wr_addr_i, req_line_i, rsp_line_o, last_line;
	lease_pkg::lease_word_u wr_data_i;
	logic        req_valid_i, req_hit_i, req_ready_o, rsp_ready_i;
	logic [15:0] req_ref_i;
	logic        rsp_valid_o, rsp_swap_o, rsp_default_o, rsp_expired_o, rsp_multi_o, rsp_random_o;
	logic [63:0] cases [64]; // op, line/addr, ref, stall, then data or expected fields
	logic [31:0] seed;
	int          stall;

	lease_cache_policy lease_cache_policy_inst (.*);

	always #4 clock_i = ~clock_i;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("failure at %0t: %s", $time, why);
		$display("STATUS: FAIL");
		$fatal(1, "aborted");
	endtask

	// starts and ends on a falling edge
	task automatic host_write(input logic llt, input logic [3:0] addr, input logic [31:0] data);
		llt_wren_i = llt;
		cfg_wren_i = !llt;
		wr_addr_i  = addr;
		wr_data_i  = data;
		@(negedge clock_i);
		llt_wren_i = 1'b0;
		cfg_wren_i = 1'b0;
	endtask

	task automatic issue_request(input logic hit, input logic [3:0] line, input logic [15:0] rref);
		int n;
		req_valid_i = 1'b1;
		req_hit_i   = hit;
		req_line_i  = line;
		req_ref_i   = rref;
		n = 0;
		while (!req_ready_o) begin
			@(negedge clock_i);
			n++;
			if (n > 20) abort_run("request channel never became ready");
		end
		@(negedge clock_i); // taken on the rising edge just passed
		req_valid_i = 1'b0;
	endtask

	task automatic run_miss(input logic [63:0] rec, input int stall_n);
		int         n;
		logic [3:0] mask;
		logic [8:0] held;
		issue_request(1'b0, rec[59:56], rec[55:40]);
		n = 1;
		while (!rsp_valid_o) begin
			check_value(req_ready_o, 0, "req_ready_o while miss pending");
			@(negedge clock_i);
			n++;
			if (n > 20) abort_run("no response arrived for a miss");
		end
		check_value(n, rec[24] ? 2 : 1, "cycles from acceptance to response");
		mask = rec[8] ? 4'h3 : 4'hf; // a random victim is only known by its set
		check_value(rsp_line_o & mask, rec[31:28] & mask, "rsp_line_o");
		check_value({rsp_swap_o, rsp_default_o, rsp_expired_o, rsp_multi_o, rsp_random_o},
			{rec[24], rec[20], rec[16], rec[12], rec[8]}, "response flags");
		held = {rsp_line_o, rsp_swap_o, rsp_default_o, rsp_expired_o, rsp_multi_o, rsp_random_o};
		for (n = 0; n < stall_n; n++) begin // back-pressure, everything must hold
			@(negedge clock_i);
			check_value(rsp_valid_o, 1, "rsp_valid_o under back-pressure");
			check_value({rsp_line_o, rsp_swap_o, rsp_default_o, rsp_expired_o, rsp_multi_o,
				rsp_random_o}, held, "response under back-pressure");
			check_value(req_ready_o, 0, "req_ready_o under back-pressure");
		end
		last_line   = rsp_line_o;
		rsp_ready_i = 1'b1;
		@(negedge clock_i);
		rsp_ready_i = 1'b0;
		check_value(rsp_valid_o, 0, "rsp_valid_o after transfer");
		check_value(req_ready_o, 1, "req_ready_o after transfer");
	endtask

	initial begin
		clock_i = 1'b0;
		resetn_i = 1'b0;
		{llt_wren_i, cfg_wren_i, req_valid_i, req_hit_i, rsp_ready_i} = '0;
		{wr_addr_i, req_line_i, req_ref_i, last_line} = '0;
		wr_data_i = '0;
		seed = 32'h657b_0505;
		$readmemh("lease_cases.txt", cases);
		repeat (10) @(posedge clock_i);
		@(negedge clock_i);
		resetn_i = 1'b1;
		check_value({req_ready_o, rsp_valid_o, rsp_swap_o, rsp_default_o, rsp_expired_o,
			rsp_multi_o, rsp_random_o}, 7'b1000000, "outputs after reset");
		for (int i = 0; i < 64; i++) begin
			if (cases[i][63:60] === 4'hf) break; // end marker
			case (cases[i][63:60])
				4'h0, 4'h1: host_write(cases[i][60], cases[i][59:56], cases[i][31:0]);
				4'h2: begin
					issue_request(1'b1, cases[i][59:56], cases[i][55:40]);
					check_value(req_ready_o, 1, "req_ready_o after a hit");
				end
				4'h3: run_miss(cases[i], 0);
				4'h4: begin
					stall = cases[i][39:32];
					if (stall == 0) begin // length left to the generator
						seed  = xorshift(seed);
						stall = 1 + seed[2:0];
					end
					run_miss(cases[i], stall);
				end
				4'h5: issue_request(1'b1, last_line, cases[i][55:40]); // fill the victim
				default: abort_run("unknown operation in the case file");
			endcase
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== lease_cache_policy.sv ====
/* lease based replacement policy, top level
   host writes the table and config, the cache controller sends hits and misses */
module lease_cache_policy (
	input  logic                               clock_i,
	input  logic                               resetn_i,
	input  logic                               llt_wren_i,  // table write
	input  logic                               cfg_wren_i,  // config write
	input  logic [lease_pkg::wr_addr_bw-1:0]   wr_addr_i,
	input  lease_pkg::lease_word_u             wr_data_i,
	input  logic                               req_valid_i,
	input  logic                               req_hit_i,
	input  logic [cache_geom_pkg::line_bw-1:0] req_line_i,
	input  logic [lease_pkg::ref_bw-1:0]       req_ref_i,
	output logic                               req_ready_o,
	output logic                               rsp_valid_o,
	output logic [cache_geom_pkg::line_bw-1:0] rsp_line_o,
	output logic                               rsp_swap_o,
	output logic                               rsp_default_o,
	output logic                               rsp_expired_o,
	output logic                               rsp_multi_o,
	output logic                               rsp_random_o,
	input  logic                               rsp_ready_i
);

	logic                               table_hit, sel_default, decay, renew, draw, alloc;
	logic [lease_pkg::lease_bw-1:0]     table_lease, sel_lease, renew_lease;
	logic [cache_geom_pkg::line_bw-1:0] renew_line, victim_line;
	logic [cache_geom_pkg::n_lines-1:0] expired;
	logic                               vic_expired, vic_multi, vic_random;
	logic [cache_geom_pkg::set_bw-1:0]  set_q; // set of the miss in flight

	// set index from the low line bits, held past acceptance for the victim lookup
	always_ff @(posedge clock_i) begin
		if (req_valid_i && req_ready_o) set_q <= req_line_i[cache_geom_pkg::set_bw-1:0];
	end

	// submodules ------------------------------
	lease_lookup_table lease_lookup_table_inst (
		.clock_i, .resetn_i, .wren_i(llt_wren_i),
		.addr_i(wr_addr_i[lease_pkg::llt_idx_bw-1:0]), .data_i(wr_data_i),
		.search_ref_i(req_ref_i), .hit_o(table_hit), .lease_o(table_lease));

	lease_selector lease_selector_inst (
		.clock_i, .resetn_i, .cfg_wren_i, .cfg_addr_i(wr_addr_i), .cfg_data_i(wr_data_i),
		.ref_i(req_ref_i), .table_hit_i(table_hit), .table_lease_i(table_lease),
		.draw_i(draw), .lease_o(sel_lease), .default_o(sel_default));

	lease_register_file lease_register_file_inst (
		.clock_i, .resetn_i, .decay_i(decay), .renew_i(renew),
		.renew_line_i(renew_line), .renew_lease_i(renew_lease), .expired_o(expired));

	victim_selector victim_selector_inst (
		.clock_i, .resetn_i, .set_i(set_q), .expired_i(expired), .alloc_i(alloc),
		.victim_line_o(victim_line), .expired_o(vic_expired), .multi_o(vic_multi),
		.random_o(vic_random));

	lease_policy_fsm lease_policy_fsm_inst (
		.clock_i, .resetn_i, .req_valid_i, .req_hit_i, .req_line_i, .req_ready_o,
		.rsp_valid_o, .rsp_line_o, .rsp_swap_o, .rsp_default_o, .rsp_expired_o,
		.rsp_multi_o, .rsp_random_o, .rsp_ready_i,
		.lease_i(sel_lease), .default_i(sel_default), .victim_line_i(victim_line),
		.victim_expired_i(vic_expired), .victim_multi_i(vic_multi),
		.victim_random_i(vic_random), .decay_o(decay), .renew_o(renew),
		.renew_line_o(renew_line), .renew_lease_o(renew_lease), .draw_o(draw),
		.alloc_o(alloc));

endmodule

// ==== lease_policy_fsm.sv ====
/* sequences requests into lease decay, renewal and victim draws
   and holds the miss response until the host takes it */
module lease_policy_fsm (
	input  logic                               clock_i,
	input  logic                               resetn_i,
	input  logic                               req_valid_i,
	input  logic                               req_hit_i,
	input  logic [cache_geom_pkg::line_bw-1:0] req_line_i,
	output logic                               req_ready_o,
	output logic                               rsp_valid_o,
	output logic [cache_geom_pkg::line_bw-1:0] rsp_line_o,
	output logic                               rsp_swap_o,
	output logic                               rsp_default_o,
	output logic                               rsp_expired_o,
	output logic                               rsp_multi_o,
	output logic                               rsp_random_o,
	input  logic                               rsp_ready_i,
	input  logic [lease_pkg::lease_bw-1:0]     lease_i,          // lease of the current ref
	input  logic                               default_i,
	input  logic [cache_geom_pkg::line_bw-1:0] victim_line_i,
	input  logic                               victim_expired_i,
	input  logic                               victim_multi_i,
	input  logic                               victim_random_i,
	output logic                               decay_o,
	output logic                               renew_o,
	output logic [cache_geom_pkg::line_bw-1:0] renew_line_o,
	output logic [lease_pkg::lease_bw-1:0]     renew_lease_o,
	output logic                               draw_o,
	output logic                               alloc_o
);

	localparam logic [1:0] st_idle     = 2'd0;
	localparam logic [1:0] st_generate = 2'd1; // victim lookup for a swap miss
	localparam logic [1:0] st_respond  = 2'd2;

	logic [1:0]                     state_q;
	logic                           followup_q;    // next accepted hit is the fill
	logic [lease_pkg::lease_bw-1:0] saved_lease_q; // lease for the filled line
	logic                           accept;
	logic                           fill;

	assign req_ready_o = (state_q == st_idle);
	assign accept      = req_valid_i && req_ready_o;
	assign fill        = accept && req_hit_i && followup_q;

	// strobes out ------------------------------
	assign decay_o       = accept && !fill;      // fill hit leaves the others alone
	assign draw_o        = accept && !fill;
	assign renew_o       = accept && req_hit_i;
	assign renew_line_o  = req_line_i;
	assign renew_lease_o = followup_q ? saved_lease_q : lease_i;
	assign alloc_o       = (state_q == st_generate);

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q       <= st_idle;
			followup_q    <= 1'b0;
			rsp_valid_o   <= 1'b0;
			rsp_swap_o    <= 1'b0;
			rsp_default_o <= 1'b0;
			rsp_expired_o <= 1'b0;
			rsp_multi_o   <= 1'b0;
			rsp_random_o  <= 1'b0;
		end else begin
			case (state_q)
				st_idle: begin
					if (accept && req_hit_i) begin
						followup_q <= 1'b0;
					end else if (accept) begin
						rsp_default_o <= default_i;
						rsp_expired_o <= 1'b0;
						rsp_multi_o   <= 1'b0;
						rsp_random_o  <= 1'b0;
						if (lease_i != '0) begin
							saved_lease_q <= lease_i;
							followup_q    <= 1'b1;
							state_q       <= st_generate;
						end else begin
							// zero lease: just service it, nothing allocated
							rsp_valid_o <= 1'b1;
							rsp_swap_o  <= 1'b0;
							rsp_line_o  <= req_line_i;
							state_q     <= st_respond;
						end
					end
				end
				st_generate: begin
					rsp_valid_o   <= 1'b1;
					rsp_swap_o    <= 1'b1;
					rsp_line_o    <= victim_line_i;
					rsp_expired_o <= victim_expired_i;
					rsp_multi_o   <= victim_multi_i;
					rsp_random_o  <= victim_random_i;
					state_q       <= st_respond;
				end
				default: begin // st_respond, wait for the host
					if (rsp_ready_i) begin
						rsp_valid_o <= 1'b0;
						state_q     <= st_idle;
					end
				end
			endcase
		end
	end

	// response holds under back-pressure
	assert property (@(posedge clock_i) disable iff (!resetn_i)
		rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable({rsp_line_o, rsp_swap_o,
			rsp_default_o, rsp_expired_o, rsp_multi_o, rsp_random_o}))
		else $error("response changed while stalled");

	// a miss blocks the request channel up to its response transfer
	assert property (@(posedge clock_i) disable iff (!resetn_i)
		accept && !req_hit_i |=> !req_ready_o until_with (rsp_valid_o && rsp_ready_i))
		else $error("request accepted while a response was pending");

endmodule

// ==== victim_selector.sv ====
/* picks the line to replace in the requested set
   cold-start fill first, then lowest expired way, then a random way */
module victim_selector (
	input  logic                               clock_i,
	input  logic                               resetn_i,
	input  logic [cache_geom_pkg::set_bw-1:0]  set_i,
	input  logic [cache_geom_pkg::n_lines-1:0] expired_i,
	input  logic                               alloc_i,       // victim is taken this cycle
	output logic [cache_geom_pkg::line_bw-1:0] victim_line_o,
	output logic                               expired_o,
	output logic                               multi_o,
	output logic                               random_o
);

	logic [cache_geom_pkg::way_bw-1:0] cold_way_q [cache_geom_pkg::n_sets]; // next way to fill
	logic [cache_geom_pkg::n_sets-1:0] full_q;    // set done with cold start
	logic [3:0]                        lfsr_q;    // x^4+x^3+1
	logic [cache_geom_pkg::n_ways-1:0] set_exp;   // expired flags of the requested set
	logic [cache_geom_pkg::way_bw-1:0] exp_way;
	logic [cache_geom_pkg::way_bw-1:0] way;
	logic                              set_full;
	logic                              any_exp;

	// gather the set's ways out of the line vector and encode the lowest
	always_comb begin
		exp_way = '0;
		for (int w = cache_geom_pkg::n_ways - 1; w >= 0; w--) begin
			set_exp[w] = expired_i[w * cache_geom_pkg::n_sets + set_i];
			if (set_exp[w]) exp_way = w[cache_geom_pkg::way_bw-1:0];
		end
	end

	assign set_full = full_q[set_i];
	assign any_exp  = |set_exp;

	always_comb begin
		if (!set_full) way = cold_way_q[set_i];
		else if (any_exp) way = exp_way;
		else way = lfsr_q[cache_geom_pkg::way_bw-1:0]; // random fallback
	end

	assign victim_line_o = {way, set_i};
	assign expired_o     = set_full && any_exp;
	assign multi_o       = expired_o && ((set_exp & (set_exp - 1'b1)) != '0); // 2+ bits set
	assign random_o      = set_full && !any_exp;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int s = 0; s < cache_geom_pkg::n_sets; s++) cold_way_q[s] <= '0;
			full_q <= '0;
			lfsr_q <= 4'b1001;
		end else if (alloc_i) begin
			if (!set_full) begin
				cold_way_q[set_i] <= cold_way_q[set_i] + 1'b1;
				if (cold_way_q[set_i] == '1) full_q[set_i] <= 1'b1; // last way handed out
			end else if (random_o) begin
				lfsr_q <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]}; // only random picks consume it
			end
		end
	end

	// at each pick a full set has wrapped its cold-start count back to way 0
	// and the random lfsr has not locked up at zero
	assert property (@(posedge clock_i) disable iff (!resetn_i)
		alloc_i |-> (lfsr_q != '0) && (!set_full || (cold_way_q[set_i] == '0)))
		else $error("cold-start count out of step with the full flag or lfsr stuck at zero");

endmodule

// ==== lease_register_file.sv ====
/* one lease counter per cache line
   decays on every non-fill access, reloads on renew, zero means expired */
module lease_register_file (
	input  logic                                clock_i,
	input  logic                                resetn_i,
	input  logic                                decay_i,
	input  logic                                renew_i,
	input  logic [cache_geom_pkg::line_bw-1:0]  renew_line_i,
	input  logic [lease_pkg::lease_bw-1:0]      renew_lease_i,
	output logic [cache_geom_pkg::n_lines-1:0]  expired_o
);

	logic [lease_pkg::lease_bw-1:0] lease_q [cache_geom_pkg::n_lines];

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int i = 0; i < cache_geom_pkg::n_lines; i++) lease_q[i] <= '0;
		end else begin
			// decay saturates at zero
			for (int i = 0; i < cache_geom_pkg::n_lines; i++) begin
				if (decay_i && (lease_q[i] != '0)) lease_q[i] <= lease_q[i] - 1'b1;
			end
			if (renew_i) lease_q[renew_line_i] <= renew_lease_i; // later assignment, beats decay
		end
	end

	always_comb begin
		for (int i = 0; i < cache_geom_pkg::n_lines; i++) expired_o[i] = (lease_q[i] == '0);
	end

endmodule

// ==== lease_selector.sv ====
/* config registers and lease choice for the current reference
   the dual ref picks between the table lease and lease1 with an lfsr byte */
module lease_selector (
	input  logic                             clock_i,
	input  logic                             resetn_i,
	input  logic                             cfg_wren_i,
	input  logic [lease_pkg::wr_addr_bw-1:0] cfg_addr_i,
	input  lease_pkg::lease_word_u           cfg_data_i,
	input  logic [lease_pkg::ref_bw-1:0]     ref_i,
	input  logic                             table_hit_i,
	input  logic [lease_pkg::lease_bw-1:0]   table_lease_i,
	input  logic                             draw_i,       // step the lfsr
	output logic [lease_pkg::lease_bw-1:0]   lease_o,
	output logic                             default_o     // default lease was used
);

	logic [lease_pkg::lease_bw-1:0] default_lease_q;
	logic [lease_pkg::lease_bw-1:0] lease1_q;
	logic [lease_pkg::prob_bw-1:0]  thresh_q;   // table lease while lfsr < thresh
	logic [lease_pkg::ref_bw-1:0]   dual_ref_q;
	logic [lease_pkg::prob_bw-1:0]  lfsr_q;     // galois, taps 8'hb8
	logic                           dual_hit;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			default_lease_q <= '0;
			lease1_q        <= '0;
			thresh_q        <= '0;
			dual_ref_q      <= '0;
			lfsr_q          <= 8'hA1;
		end else begin
			if (cfg_wren_i) begin
				case (cfg_addr_i)
					lease_pkg::cfg_default_lease: default_lease_q <= cfg_data_i.cfg.value[7:0];
					lease_pkg::cfg_lease1:        lease1_q        <= cfg_data_i.cfg.value[7:0];
					lease_pkg::cfg_dual_prob:     thresh_q        <= cfg_data_i.cfg.value[7:0];
					lease_pkg::cfg_dual_ref:      dual_ref_q      <= cfg_data_i.cfg.value;
					default: ;                    // unmapped address, ignored
				endcase
			end
			if (draw_i) lfsr_q <= {1'b0, lfsr_q[7:1]} ^ (lfsr_q[0] ? 8'hB8 : 8'h00);
		end
	end

	assign dual_hit = table_hit_i && (ref_i == dual_ref_q);

	always_comb begin
		if (!table_hit_i) lease_o = default_lease_q;
		else if (dual_hit && (lfsr_q >= thresh_q)) lease_o = lease1_q; // threshold 0 -> always lease1
		else lease_o = table_lease_i;
	end
	assign default_o = !table_hit_i;

endmodule

// ==== lease_lookup_table.sv ====
/* host written table of reference -> lease, searched in parallel
   the lowest matching entry wins */
module lease_lookup_table (
	input  logic                             clock_i,
	input  logic                             resetn_i,
	input  logic                             wren_i,       // host write strobe
	input  logic [lease_pkg::llt_idx_bw-1:0] addr_i,       // entry to write
	input  lease_pkg::lease_word_u           data_i,
	input  logic [lease_pkg::ref_bw-1:0]     search_ref_i,
	output logic                             hit_o,
	output logic [lease_pkg::lease_bw-1:0]   lease_o
);

	logic [lease_pkg::llt_entries-1:0] valid_q;
	logic [lease_pkg::ref_bw-1:0]      ref_q   [lease_pkg::llt_entries];
	logic [lease_pkg::lease_bw-1:0]    lease_q [lease_pkg::llt_entries];
	logic [lease_pkg::llt_entries-1:0] match;  // one bit per valid entry hitting the search

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
			for (int i = 0; i < lease_pkg::llt_entries; i++) begin
				ref_q[i]   <= '0;
				lease_q[i] <= '0;
			end
		end else if (wren_i) begin
			valid_q[addr_i] <= 1'b1;                    // a written entry is live
			ref_q[addr_i]   <= data_i.entry.ref_addr;
			lease_q[addr_i] <= data_i.entry.lease;
		end
	end

	// parallel compare, then walk down so the lowest index ends up in lease_o
	always_comb begin
		lease_o = '0;
		for (int i = lease_pkg::llt_entries - 1; i >= 0; i--) begin
			match[i] = valid_q[i] && (ref_q[i] == search_ref_i);
			if (match[i]) lease_o = lease_q[i];
		end
	end
	assign hit_o = |match;

	// the host should never load the same reference twice
	assert property (@(posedge clock_i) disable iff (!resetn_i) $onehot0(match))
		else $error("lease table holds duplicate references");

endmodule

// ==== lease_pkg.sv ====
/* lease widths, config register map and the host write word
   the write word is decoded as a table entry or as a config value */
package lease_pkg;

	localparam int lease_bw    = 8;  // lease counter width
	localparam int prob_bw     = 8;  // dual lease threshold, compared with an lfsr byte
	localparam int ref_bw      = 16; // reference address
	localparam int llt_entries = 8;
	localparam int llt_idx_bw  = 3;
	localparam int wr_addr_bw  = 4;  // host write address

	// config register map
	// ------------------------------
	localparam logic [wr_addr_bw-1:0] cfg_default_lease = 4'd0; // lease on a table miss
	localparam logic [wr_addr_bw-1:0] cfg_lease1        = 4'd1; // second lease of the dual ref
	localparam logic [wr_addr_bw-1:0] cfg_dual_prob     = 4'd2; // threshold for the table lease
	localparam logic [wr_addr_bw-1:0] cfg_dual_ref      = 4'd3;

	// host write word, same 32 bits seen two ways
	typedef union packed {
		struct packed {
			logic [ref_bw-1:0]   ref_addr; // reference this entry answers
			logic [7:0]          rsvd;
			logic [lease_bw-1:0] lease;
		} entry;
		struct packed {
			logic [15:0] rsvd;
			logic [15:0] value;            // low bits used per register
		} cfg;
	} lease_word_u;

endpackage

// ==== cache_geom_pkg.sv ====
/* cache geometry for the lease replacement policy
   a line address is {way, set}, so the set sits in the low bits */
package cache_geom_pkg;

	localparam int n_lines = 16; // lines in the whole cache
	localparam int n_ways  = 4;  // ways per set
	localparam int n_sets  = 4;

	// address field widths
	localparam int line_bw = 4;
	localparam int way_bw  = 2;  // upper bits of a line address
	localparam int set_bw  = 2;  // lower bits of a line address

endpackage
